/* src.f */
lsu_pkg.sv
lsu.sv
axi_mem.sv
lsu_top.sv
lsu_asserts.sv
tb_lsu.sv

/* run.sh */
#!/bin/sh
# build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f src.f --top-module tb_lsu -o tb_lsu_sim

./obj_dir/tb_lsu_sim > sim.log 2>&1
cat sim.log

if grep -q "Something failed" sim.log; then
  echo "simulation reported errors"
  exit 1
fi
echo "simulation passed"

/* tb_lsu.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_lsu;

  // one row of the stimulus table
  typedef struct packed {
    logic              is_store;
    lsu_pkg::ld_func_t ld_f;
    lsu_pkg::st_func_t st_f;
    lsu_pkg::addr_t    addr;
    lsu_pkg::word_t    data;
  } entry_t;

  logic               clk = 1'b0;
  logic               rstn;
  lsu_pkg::ld_req_t   ld_req;
  logic               ld_valid;
  logic               ld_ready;
  lsu_pkg::word_t     ld_data;
  logic               ld_rsp_valid;
  logic               ld_rsp_ready;
  lsu_pkg::st_req_t   st_req;
  logic               st_valid;
  logic               st_ready;
  logic               st_rsp_valid;
  logic               st_rsp_ready;

  entry_t             stim [$];
  // byte image of the first 2 KiB of memory
  logic [7:0]         model [0:2047];
  logic [31:0]        rng_state;
  int                 err_cnt;
  int                 cycle_cnt = 0;
  int                 cycle_limit = 100000;

  lsu_top #(
    .MEM_LINES (256)
  ) uut (
    .clk          (clk),
    .rstn         (rstn),
    .ld_req       (ld_req),
    .ld_valid     (ld_valid),
    .ld_ready     (ld_ready),
    .ld_data      (ld_data),
    .ld_rsp_valid (ld_rsp_valid),
    .ld_rsp_ready (ld_rsp_ready),
    .st_req       (st_req),
    .st_valid     (st_valid),
    .st_ready     (st_ready),
    .st_rsp_valid (st_rsp_valid),
    .st_rsp_ready (st_rsp_ready)
  );

  bind lsu_top lsu_asserts u_asserts (
    .clk          (clk),
    .rstn         (rstn),
    .ld_data      (ld_data),
    .ld_rsp_valid (ld_rsp_valid),
    .ld_rsp_ready (ld_rsp_ready),
    .st_valid     (st_valid),
    .st_ready     (st_ready),
    .st_rsp_valid (st_rsp_valid),
    .st_rsp_ready (st_rsp_ready),
    .aw           (aw),
    .awvalid      (awvalid),
    .w            (w)
  );

  always #20 clk = ~clk;

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= cycle_limit) begin
      $display("timeout: the table did not finish within %0d cycles", cycle_limit);
      $display("Something failed");
      $finish;
    end
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic roll_ready(output logic r);
    rng_state = xorshift32(rng_state);
    r = rng_state[7];
  endtask

  function automatic logic [7:0] mem_byte(input lsu_pkg::addr_t a);
    return model[a[10:0]];
  endfunction

  // load value rebuilt byte by byte from the model
  function automatic lsu_pkg::word_t expected_load(input lsu_pkg::ld_func_t f,
                                                   input lsu_pkg::addr_t a);
    logic [7:0]  b;
    logic [15:0] h;
    b = mem_byte(a);
    h = {mem_byte(a + 32'd1), b};
    case (f)
      lsu_pkg::LD_BS: return {{24{b[7]}}, b};
      lsu_pkg::LD_BU: return {24'h0, b};
      lsu_pkg::LD_HS: return {{16{h[15]}}, h};
      lsu_pkg::LD_HU: return {16'h0, h};
      default:        return {mem_byte(a + 32'd3), mem_byte(a + 32'd2), h};
    endcase
  endfunction

  task automatic update_model(input lsu_pkg::st_func_t f, input lsu_pkg::addr_t a,
                              input lsu_pkg::word_t d);
    int         n;
    logic [10:0] idx;
    n = (f == lsu_pkg::ST_B) ? 1 : (f == lsu_pkg::ST_H) ? 2 : 4;
    for (int i = 0; i < n; i++) begin
      idx = a[10:0] + 11'(i);
      model[idx] = d[8*i +: 8];
    end
  endtask

  task automatic check_word(input lsu_pkg::word_t got, input lsu_pkg::word_t exp,
                            input string what);
    if (got !== exp) begin
      err_cnt++;
      $display("FAIL %0d ns: %s returned %08h, expected %08h", $time, what, got, exp);
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      err_cnt++;
      $display("FAIL %0d ns: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic add_st(input lsu_pkg::st_func_t f, input lsu_pkg::addr_t a,
                        input lsu_pkg::word_t d);
    stim.push_back('{is_store: 1'b1, ld_f: lsu_pkg::LD_W, st_f: f, addr: a, data: d});
  endtask

  task automatic add_ld(input lsu_pkg::ld_func_t f, input lsu_pkg::addr_t a);
    stim.push_back('{is_store: 1'b0, ld_f: f, st_f: lsu_pkg::ST_W, addr: a, data: '0});
  endtask

  task automatic do_store(input entry_t e);
    logic r;
    @(negedge clk);
    st_req = '{addr: e.addr, func: e.st_f, data: e.data};
    st_valid = 1'b1;
    #1;
    while (!st_ready) begin
      @(negedge clk);
      #1;
    end
    // request taken on the edge just passed
    @(negedge clk);
    st_valid = 1'b0;
    update_model(e.st_f, e.addr, e.data);
    roll_ready(r);
    st_rsp_ready = r;
    #1;
    while (!(st_rsp_valid && st_rsp_ready)) begin
      @(negedge clk);
      roll_ready(r);
      st_rsp_ready = r;
      #1;
    end
    @(negedge clk);
    st_rsp_ready = 1'b0;
    #1;
    check_bit(st_rsp_valid, 1'b0, "st_rsp_valid after the response was taken");
  endtask

  task automatic do_load(input entry_t e);
    logic            r;
    lsu_pkg::word_t  exp;
    exp = expected_load(e.ld_f, e.addr);
    @(negedge clk);
    ld_req = '{addr: e.addr, func: e.ld_f};
    ld_valid = 1'b1;
    #1;
    while (!ld_ready) begin
      @(negedge clk);
      #1;
    end
    @(negedge clk);
    ld_valid = 1'b0;
    roll_ready(r);
    ld_rsp_ready = r;
    #1;
    while (!(ld_rsp_valid && ld_rsp_ready)) begin
      @(negedge clk);
      roll_ready(r);
      ld_rsp_ready = r;
      #1;
    end
    check_word(ld_data, exp, $sformatf("%s at %08h", e.ld_f.name(), e.addr));
    @(negedge clk);
    ld_rsp_ready = 1'b0;
    #1;
    check_bit(ld_rsp_valid, 1'b0, "ld_rsp_valid after the response was taken");
  endtask

  initial begin
    rstn         = 1'b0;
    ld_req       = '0;
    ld_valid     = 1'b0;
    ld_rsp_ready = 1'b0;
    st_req       = '0;
    st_valid     = 1'b0;
    st_rsp_ready = 1'b0;
    rng_state    = 32'h6130_ceea;
    err_cnt      = 0;

    // full words in both halves of one line
    add_st(lsu_pkg::ST_W, 'h100, 'h89ab_cdef);
    add_st(lsu_pkg::ST_W, 'h104, 'h70e1_52c3);
    add_ld(lsu_pkg::LD_W, 'h100);
    add_ld(lsu_pkg::LD_W, 'h104);
    // byte and half merges, upper data bits must be ignored
    add_st(lsu_pkg::ST_W, 'h108, 'h8877_6655);
    for (int i = 0; i < 4; i++) begin
      add_st(lsu_pkg::ST_B, 32'h108 + i, 32'hdead_be00 + i);
      add_ld(lsu_pkg::LD_W, 'h108);
    end
    add_st(lsu_pkg::ST_W, 'h110, 'hfedc_ba98);
    for (int i = 0; i < 2; i++) begin
      add_st(lsu_pkg::ST_H, 32'h110 + 2 * i, 32'h5a5a_8e10 + i);
      add_ld(lsu_pkg::LD_W, 'h110);
    end
    // sign and zero extension at every aligned offset
    for (int a = 'h100; a < 'h108; a++) begin
      add_ld(lsu_pkg::LD_BS, a);
      add_ld(lsu_pkg::LD_BU, a);
    end
    for (int a = 'h100; a < 'h108; a += 2) begin
      add_ld(lsu_pkg::LD_HS, a);
      add_ld(lsu_pkg::LD_HU, a);
    end
    cycle_limit = stim.size() * 40 + 16;

    repeat (8) @(negedge clk);
    rstn = 1'b1;
    // nothing requested yet, so no response may show up
    repeat (4) begin
      @(negedge clk);
      #1;
      check_bit(ld_rsp_valid, 1'b0, "ld_rsp_valid after reset");
      check_bit(st_rsp_valid, 1'b0, "st_rsp_valid after reset");
    end

    foreach (stim[i]) begin
      if (stim[i].is_store) begin
        do_store(stim[i]);
      end else begin
        do_load(stim[i]);
      end
    end

    $display("%0d errors over %0d table entries", err_cnt, stim.size());
    if (err_cnt == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* lsu_asserts.sv */
`timescale 1ns/1ps
`default_nettype none

module lsu_asserts (
  input logic           clk,
  input logic           rstn,
  input lsu_pkg::word_t ld_data,
  input logic           ld_rsp_valid,
  input logic           ld_rsp_ready,
  input logic           st_valid,
  input logic           st_ready,
  input logic           st_rsp_valid,
  input logic           st_rsp_ready,
  input lsu_pkg::aw_t   aw,
  input logic           awvalid,
  input lsu_pkg::w_t    w
);

  // stalled load response keeps valid and data
  ld_rsp_hold: assert property (@(posedge clk) disable iff (!rstn)
    ld_rsp_valid && !ld_rsp_ready |=> ld_rsp_valid && $stable(ld_data))
    else $error("load response dropped or changed while stalled");

  st_rsp_hold: assert property (@(posedge clk) disable iff (!rstn)
    st_rsp_valid && !st_rsp_ready |=> st_rsp_valid)
    else $error("store response dropped while stalled");

  // both slots are full after the st_ready edge,
  // so the line is written next and the response follows
  st_ready_phases: assert property (@(posedge clk) disable iff (!rstn)
    st_valid && st_ready |-> ##2 st_rsp_valid)
    else $error("st_ready high before both write phases were accepted");

  // size code agrees with the number of strobed bytes
  aw_size_strb: assert property (@(posedge clk) disable iff (!rstn)
    awvalid |-> $countones(w.wstrb) == (1 << aw.awsize))
    else $error("awsize does not match the write strobes");

endmodule

`default_nettype wire

/* lsu_top.sv */
`timescale 1ns/1ps
`default_nettype none

module lsu_top #(
  parameter int MEM_LINES = 256
) (
  input  logic              clk,
  input  logic              rstn,
  // load side
  input  lsu_pkg::ld_req_t  ld_req,
  input  logic              ld_valid,
  output logic              ld_ready,
  output lsu_pkg::word_t    ld_data,
  output logic              ld_rsp_valid,
  input  logic              ld_rsp_ready,
  // store side
  input  lsu_pkg::st_req_t  st_req,
  input  logic              st_valid,
  output logic              st_ready,
  output logic              st_rsp_valid,
  input  logic              st_rsp_ready
);

  // bus between the unit and the memory
  lsu_pkg::ar_t   ar;
  logic           arvalid;
  logic           arready;
  lsu_pkg::word_t rdata;
  logic           rvalid;
  logic           rready;
  lsu_pkg::aw_t   aw;
  logic           awvalid;
  logic           awready;
  lsu_pkg::w_t    w;
  logic           wvalid;
  logic           wready;
  logic           bvalid;
  logic           bready;

  lsu u_lsu (
    .clk          (clk),
    .rstn         (rstn),
    .ld_req       (ld_req),
    .ld_valid     (ld_valid),
    .ld_ready     (ld_ready),
    .ld_data      (ld_data),
    .ld_rsp_valid (ld_rsp_valid),
    .ld_rsp_ready (ld_rsp_ready),
    .st_req       (st_req),
    .st_valid     (st_valid),
    .st_ready     (st_ready),
    .st_rsp_valid (st_rsp_valid),
    .st_rsp_ready (st_rsp_ready),
    .ar           (ar),
    .arvalid      (arvalid),
    .arready      (arready),
    .rdata        (rdata),
    .rvalid       (rvalid),
    .rready       (rready),
    .aw           (aw),
    .awvalid      (awvalid),
    .awready      (awready),
    .w            (w),
    .wvalid       (wvalid),
    .wready       (wready),
    .bvalid       (bvalid),
    .bready       (bready)
  );

  axi_mem #(
    .MEM_LINES (MEM_LINES)
  ) u_mem (
    .clk     (clk),
    .rstn    (rstn),
    .ar      (ar),
    .arvalid (arvalid),
    .arready (arready),
    .rdata   (rdata),
    .rvalid  (rvalid),
    .rready  (rready),
    .aw      (aw),
    .awvalid (awvalid),
    .awready (awready),
    .w       (w),
    .wvalid  (wvalid),
    .wready  (wready),
    .bvalid  (bvalid),
    .bready  (bready)
  );

endmodule

`default_nettype wire

/* axi_mem.sv */
`timescale 1ns/1ps
`default_nettype none

module axi_mem #(
  parameter int MEM_LINES = 256
) (
  input  logic              clk,
  input  logic              rstn,
  // read address and data
  input  lsu_pkg::ar_t      ar,
  input  logic              arvalid,
  output logic              arready,
  output lsu_pkg::word_t    rdata,
  output logic              rvalid,
  input  logic              rready,
  // write address, data and response
  input  lsu_pkg::aw_t      aw,
  input  logic              awvalid,
  output logic              awready,
  input  lsu_pkg::w_t       w,
  input  logic              wvalid,
  output logic              wready,
  output logic              bvalid,
  input  logic              bready
);

  // line index bits, taken from above the 8-byte offset
  localparam int IDX_W = (MEM_LINES > 1) ? $clog2(MEM_LINES) : 1;

  lsu_pkg::line_t     mem [MEM_LINES];

  logic [IDX_W-1:0]   rd_idx;
  logic [IDX_W-1:0]   wr_idx;

  // captured write phases
  lsu_pkg::addr_t     awaddr_q;
  lsu_pkg::w_t        w_q;
  logic               aw_full;
  logic               w_full;
  logic               wr_commit;

  assign rd_idx = ar.araddr[3 +: IDX_W];
  assign wr_idx = awaddr_q[3 +: IDX_W];

  // one read in flight
  assign arready = !rvalid;

  always_ff @(posedge clk) begin
    if (!rstn) begin
      rvalid <= 1'b0;
    end else if (arvalid && arready) begin
      rvalid <= 1'b1;
    end else if (rready) begin
      rvalid <= 1'b0;
    end
  end

  // address bit 2 picks the 32-bit half of the line
  always_ff @(posedge clk) begin
    if (arvalid && arready) begin
      if (ar.araddr[2]) begin
        rdata <= mem[rd_idx][63:32];
      end else begin
        rdata <= mem[rd_idx][31:0];
      end
    end
  end

  // slots only take a phase while empty and no response is waiting
  assign awready = !aw_full && !bvalid;
  assign wready  = !w_full && !bvalid;

  assign wr_commit = aw_full && w_full;

  always_ff @(posedge clk) begin
    if (!rstn) begin
      aw_full <= 1'b0;
      w_full  <= 1'b0;
      bvalid  <= 1'b0;
    end else if (wr_commit) begin
      aw_full <= 1'b0;
      w_full  <= 1'b0;
      bvalid  <= 1'b1;
    end else begin
      if (awvalid && awready) begin
        aw_full <= 1'b1;
      end
      if (wvalid && wready) begin
        w_full <= 1'b1;
      end
      if (bvalid && bready) begin
        bvalid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (awvalid && awready) begin
      awaddr_q <= aw.awaddr;
    end
    if (wvalid && wready) begin
      w_q <= w;
    end
  end

  // byte lanes with the strobe set are written, the rest stay
  always_ff @(posedge clk) begin
    if (wr_commit) begin
      for (int i = 0; i < lsu_pkg::LINE_BYTES; i++) begin
        if (w_q.wstrb[i]) begin
          mem[wr_idx][8*i +: 8] <= w_q.wdata[8*i +: 8];
        end
      end
    end
  end

endmodule

`default_nettype wire

/* lsu.sv */
`timescale 1ns/1ps
`default_nettype none

module lsu (
  input  logic              clk,
  input  logic              rstn,
  // core load request and response
  input  lsu_pkg::ld_req_t  ld_req,
  input  logic              ld_valid,
  output logic              ld_ready,
  output lsu_pkg::word_t    ld_data,
  output logic              ld_rsp_valid,
  input  logic              ld_rsp_ready,
  // core store request and response
  input  lsu_pkg::st_req_t  st_req,
  input  logic              st_valid,
  output logic              st_ready,
  output logic              st_rsp_valid,
  input  logic              st_rsp_ready,
  // read channels
  output lsu_pkg::ar_t      ar,
  output logic              arvalid,
  input  logic              arready,
  input  lsu_pkg::word_t    rdata,
  input  logic              rvalid,
  output logic              rready,
  // write channels
  output lsu_pkg::aw_t      aw,
  output logic              awvalid,
  input  logic              awready,
  output lsu_pkg::w_t       w,
  output logic              wvalid,
  input  logic              wready,
  input  logic              bvalid,
  output logic              bready
);

  // load info kept from the address handshake until data returns
  logic [1:0]         ld_off_q;
  lsu_pkg::ld_func_t  ld_func_q;
  lsu_pkg::word_t     ld_shifted;

  // store beat construction
  lsu_pkg::size_t     st_size;
  lsu_pkg::strb_t     st_strb_base;
  lsu_pkg::line_t     st_line_base;
  logic [5:0]         st_bit_shift;

  // set while that write phase has not been accepted yet
  logic               aw_pend;
  logic               w_pend;

  // load path goes straight through to the read channels
  assign ar       = '{araddr: ld_req.addr};
  assign arvalid  = ld_valid;
  assign ld_ready = arready;

  assign ld_rsp_valid = rvalid;
  assign rready       = ld_rsp_ready;

  always_ff @(posedge clk) begin
    if (ld_valid && arready) begin
      ld_off_q  <= ld_req.addr[1:0];
      ld_func_q <= ld_req.func;
    end
  end

  // move the addressed byte down to bit 0
  assign ld_shifted = rdata >> {ld_off_q, 3'b000};

  always_comb begin
    case (ld_func_q)
      lsu_pkg::LD_BS: ld_data = {{24{ld_shifted[7]}}, ld_shifted[7:0]};
      lsu_pkg::LD_BU: ld_data = {24'b0, ld_shifted[7:0]};
      lsu_pkg::LD_HS: ld_data = {{16{ld_shifted[15]}}, ld_shifted[15:0]};
      lsu_pkg::LD_HU: ld_data = {16'b0, ld_shifted[15:0]};
      lsu_pkg::LD_W:  ld_data = ld_shifted;
      default:        ld_data = ld_shifted;
    endcase
  end

  // size code and unshifted strobe per store width
  always_comb begin
    case (st_req.func)
      lsu_pkg::ST_B: begin
        st_size      = 3'd0;
        st_strb_base = 8'b0000_0001;
      end
      lsu_pkg::ST_H: begin
        st_size      = 3'd1;
        st_strb_base = 8'b0000_0011;
      end
      default: begin
        st_size      = 3'd2;
        st_strb_base = 8'b0000_1111;
      end
    endcase
  end

  // place data and strobe at the byte offset within the 64-bit line
  assign st_line_base = {32'b0, st_req.data};
  assign st_bit_shift = {st_req.addr[2:0], 3'b000};

  assign aw = '{awaddr: st_req.addr, awsize: st_size};
  assign w  = '{wdata: st_line_base << st_bit_shift,
                wstrb: st_strb_base << st_req.addr[2:0]};

  assign awvalid = st_valid && aw_pend;
  assign wvalid  = st_valid && w_pend;

  // done once each phase is taken now or was taken before
  assign st_ready = ((awvalid && awready) || !aw_pend) &&
                    ((wvalid && wready) || !w_pend);

  always_ff @(posedge clk) begin
    if (!rstn) begin
      aw_pend <= 1'b1;
      w_pend  <= 1'b1;
    end else if (bvalid && bready) begin
      aw_pend <= 1'b1;
      w_pend  <= 1'b1;
    end else begin
      if (awvalid && awready) begin
        aw_pend <= 1'b0;
      end
      if (wvalid && wready) begin
        w_pend <= 1'b0;
      end
    end
  end

  assign st_rsp_valid = bvalid;
  assign bready       = st_rsp_ready;

endmodule

`default_nettype wire

/* lsu_pkg.sv */
`default_nettype none

package lsu_pkg;

  // register width and bytes per write beat
  localparam int XLEN       = 32;
  localparam int LINE_BYTES = 8;

  // widths with a meaning of their own
  typedef logic [XLEN-1:0]         addr_t;
  typedef logic [XLEN-1:0]         word_t;
  typedef logic [8*LINE_BYTES-1:0] line_t;
  typedef logic [LINE_BYTES-1:0]   strb_t;

  // axi size code, log2 of the byte count
  typedef logic [2:0] size_t;

  // load function, same encoding as funct3 of the load opcode
  typedef enum logic [2:0] {
    LD_BS = 3'b000,
    LD_HS = 3'b001,
    LD_W  = 3'b010,
    LD_BU = 3'b100,
    LD_HU = 3'b101
  } ld_func_t;

  // store function, funct3 of the store opcode
  typedef enum logic [2:0] {
    ST_B = 3'b000,
    ST_H = 3'b001,
    ST_W = 3'b010
  } st_func_t;

  // core side requests
  typedef struct packed {
    addr_t    addr;
    ld_func_t func;
  } ld_req_t;

  typedef struct packed {
    addr_t    addr;
    st_func_t func;
    word_t    data;
  } st_req_t;

  // read address phase
  typedef struct packed {
    addr_t araddr;
  } ar_t;

  // write address phase
  typedef struct packed {
    addr_t awaddr;
    size_t awsize;
  } aw_t;

  // write data phase, one 64-bit beat
  typedef struct packed {
    line_t wdata;
    strb_t wstrb;
  } w_t;

endpackage

`default_nettype wire
